//--- verilog/mcr_input_pkg.sv
/*
 * Shared types and constants for the MCR2 player input path:
 * game select enum, joystick word layout, decoded control structs,
 * spinner positions, config write bundle and the input port bundle.
 */

`default_nettype none

package mcr_input_pkg;

	// ==================================================
	// Game select, coded as the downloaded mode byte
	// ==================================================
	typedef enum logic [7:0] {
		GAME_SHOLLOW  = 8'd0,
		GAME_TRON     = 8'd1,
		GAME_TWOTIGER = 8'd2,
		GAME_WACKO    = 8'd3,
		GAME_KROOZR   = 8'd4,
		GAME_DOMINO   = 8'd5
	} game_e;

	// Raw joystick word from the host
	typedef logic [31:0] joy_word_t;

	// Bit positions inside joy_word_t
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_RCW    = 8;
	localparam int JOY_RCCW   = 9;
	localparam int JOY_START1 = 10;
	localparam int JOY_START2 = 11;
	localparam int JOY_COIN   = 12;
	localparam int JOY_SPCCW  = 30;
	localparam int JOY_SPCW   = 31;

	// ==================================================
	// Decoded controls
	// ==================================================
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic rcw;
		logic rccw;
		logic spccw;
		logic spcw;
	} player_ctrl_t;

	// Both players OR'd, plus the shared start/coin buttons
	typedef struct packed {
		player_ctrl_t ctrl;
		logic         start1;
		logic         start2;
		logic         coin1;
	} merged_ctrl_t;

	typedef struct packed {
		logic [7:0] shared;
		logic [7:0] angle1;
		logic [7:0] angle2;
		logic [7:0] wx;
		logic [7:0] wy;
	} spin_pos_t;

	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} cfg_write_t;

	typedef struct packed {
		logic [7:0] port0;
		logic [7:0] port1;
		logic [7:0] port2;
		logic [7:0] port3;
		logic [7:0] port4;
	} input_ports_t;

	// Config download indexes
	localparam logic [7:0] CFG_INDEX_MODE = 8'd1;
	localparam logic [7:0] CFG_INDEX_DIP  = 8'd254;
	localparam int         DIP_COUNT      = 8;

	// Krooz'r analog stick emulation
	localparam logic [7:0] ANALOG_CENTER = 8'd100;
	localparam logic [7:0] ANALOG_SWING  = 8'd63;

endpackage

`default_nettype wire

//--- verilog/control_merge.sv
/*
 * Joystick decode: splits each raw player word into named controls
 * and ORs both players into the merged view shared by most games.
 */

`timescale 1ns/1ns
`default_nettype none

module control_merge import mcr_input_pkg::*; (
	input  joy_word_t    joy1,
	input  joy_word_t    joy2,
	output player_ctrl_t p1,
	output player_ctrl_t p2,
	output merged_ctrl_t merged
);

	function automatic player_ctrl_t decode_joy(input joy_word_t joy);
		player_ctrl_t c;
		c.right  = joy[JOY_RIGHT];
		c.left   = joy[JOY_LEFT];
		c.down   = joy[JOY_DOWN];
		c.up     = joy[JOY_UP];
		c.fire_a = joy[JOY_FIRE_A];
		c.fire_b = joy[JOY_FIRE_B];
		c.fire_c = joy[JOY_FIRE_C];
		c.fire_d = joy[JOY_FIRE_D];
		c.rcw    = joy[JOY_RCW];
		c.rccw   = joy[JOY_RCCW];
		c.spccw  = joy[JOY_SPCCW];
		c.spcw   = joy[JOY_SPCW];
		return c;
	endfunction

	assign p1 = decode_joy(joy1);
	assign p2 = decode_joy(joy2);

	// All fields are single bits, so a plain OR merges every control
	assign merged.ctrl   = p1 | p2;
	assign merged.start1 = joy1[JOY_START1] | joy2[JOY_START1];
	assign merged.start2 = joy1[JOY_START2] | joy2[JOY_START2];
	assign merged.coin1  = joy1[JOY_COIN] | joy2[JOY_COIN];

endmodule

`default_nettype wire

//--- verilog/game_config.sv
/*
 * Game configuration registers: mode byte and DIP-switch bank,
 * loaded from single-cycle config writes.
 */

`timescale 1ns/1ns
`default_nettype none

module game_config import mcr_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  cfg_write_t cfg,
	output game_e      game,
	output logic [7:0] dip0,
	output logic       service
);

	localparam int DIP_AW = $clog2(DIP_COUNT);

	logic [7:0] dip [DIP_COUNT];

	logic mode_wr;
	logic dip_wr;

	assign mode_wr = cfg.wr && (cfg.index == CFG_INDEX_MODE);
	// Only the first DIP_COUNT addresses hold switches
	assign dip_wr  = cfg.wr && (cfg.index == CFG_INDEX_DIP) && (cfg.addr < 25'(DIP_COUNT));

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game <= GAME_SHOLLOW;
			for (int i = 0; i < DIP_COUNT; i++) begin
				dip[i] <= 8'hff;
			end
		end else begin
			if (mode_wr) begin
				game <= game_e'(cfg.data);
			end
			if (dip_wr) begin
				dip[cfg.addr[DIP_AW-1:0]] <= cfg.data;
			end
		end
	end

	assign dip0    = dip[0];
	assign service = dip[1][0];

	// The host must only download modes known to the port mux
	a_game_defined: assert property (@(posedge clk_sys) disable iff (!rst_n)
		game inside {GAME_SHOLLOW, GAME_TRON, GAME_TWOTIGER,
			GAME_WACKO, GAME_KROOZR, GAME_DOMINO});

endmodule

`default_nettype wire

//--- verilog/spinner.sv
/*
 * Single 8-bit spinner position, stepped up or down by a fixed
 * amount on each strobe pulse.
 */

`timescale 1ns/1ns
`default_nettype none

module spinner #(
	parameter int step_size = 1
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       strobe,
	input  logic       plus,
	input  logic       minus,
	output logic [7:0] pos
);

	localparam logic [7:0] STEP = 8'(step_size);

	// Wraps modulo 256, plus has priority over minus
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (strobe) begin
			if (plus) begin
				pos <= pos + STEP;
			end else if (minus) begin
				pos <= pos - STEP;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/spinner_bank.sv
/*
 * Spinner bank: vsync rising edge detect and the five game spinners
 * (shared Tron/Krooz'r dial, Two Tigers angles, Wacko x/y axes).
 */

`timescale 1ns/1ns
`default_nettype none

module spinner_bank import mcr_input_pkg::*; #(
	parameter int spin_step_shared = 12,
	parameter int spin_step_angle  = 25,
	parameter int spin_step_axis   = 10
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  logic         vsync,
	input  player_ctrl_t p1,
	input  player_ctrl_t p2,
	input  merged_ctrl_t merged,
	output spin_pos_t    pos
);

	logic vsync_q;
	logic strobe;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vsync_q <= 1'b0;
		end else begin
			vsync_q <= vsync;
		end
	end

	// One pulse per frame
	assign strobe = vsync & ~vsync_q;

	// ==================================================
	// Spinner instances
	// ==================================================
	spinner #(.step_size(spin_step_shared)) u_shared (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (merged.ctrl.rcw | merged.ctrl.spcw),
		.minus   (merged.ctrl.rccw | merged.ctrl.spccw),
		.pos     (pos.shared)
	);

	spinner #(.step_size(spin_step_angle)) u_angle1 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (p1.rcw | p1.right | p1.spcw),
		.minus   (p1.rccw | p1.left | p1.spccw),
		.pos     (pos.angle1)
	);

	spinner #(.step_size(spin_step_angle)) u_angle2 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (p2.rcw | p2.right | p2.spcw),
		.minus   (p2.rccw | p2.left | p2.spccw),
		.pos     (pos.angle2)
	);

	// Wacko trackball axes driven from the stick
	spinner #(.step_size(spin_step_axis)) u_wx (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (merged.ctrl.right),
		.minus   (merged.ctrl.left),
		.pos     (pos.wx)
	);

	spinner #(.step_size(spin_step_axis)) u_wy (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (merged.ctrl.up),
		.minus   (merged.ctrl.down),
		.pos     (pos.wy)
	);

	a_strobe_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		strobe |=> !strobe);

endmodule

`default_nettype wire

//--- verilog/input_port_mux.sv
/*
 * Game-specific input port assembly. Builds the five active-low
 * input ports and the screen orientation, registered once.
 */

`timescale 1ns/1ns
`default_nettype none

module input_port_mux import mcr_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  game_e        game,
	input  logic [7:0]   dip0,
	input  logic         service,
	input  merged_ctrl_t merged,
	input  player_ctrl_t p1,
	input  player_ctrl_t p2,
	input  spin_pos_t    pos,
	output input_ports_t ports,
	output logic [1:0]   orientation
);

	input_ports_t ports_d;
	logic [1:0]   orient_d;
	logic         game_btn;
	player_ctrl_t m;

	assign m = merged.ctrl;

	// Extra button in port0 bit 4, differs per game
	always_comb begin
		case (game)
			GAME_TRON, GAME_KROOZR, GAME_DOMINO: game_btn = m.fire_a;
			GAME_TWOTIGER:                       game_btn = m.fire_c;
			default:                             game_btn = 1'b0;
		endcase
	end

	// ==================================================
	// Port layouts
	// ==================================================
	always_comb begin
		ports_d.port0 = ~{service, 1'b0, 1'b0, game_btn,
			merged.start2, merged.start1, 1'b0, merged.coin1};
		ports_d.port1 = 8'hff;
		ports_d.port2 = 8'hff;
		ports_d.port3 = dip0;
		ports_d.port4 = 8'hff;
		orient_d      = 2'b00;

		case (game)
			GAME_SHOLLOW: begin
				ports_d.port1 = ~{2{m.fire_a, m.fire_b, m.right, m.left}};
			end
			GAME_TRON: begin
				ports_d.port1    = ~{1'b0, pos.shared[7:1]};
				ports_d.port2    = ~{2{m.down, m.up, m.right, m.left}};
				ports_d.port3[7] = ~m.fire_a;
				ports_d.port4    = ~{1'b0, pos.shared[7:1]};
			end
			GAME_TWOTIGER: begin
				orient_d      = 2'b01;
				ports_d.port1 = ~{1'b0, pos.angle1[7:1]};
				ports_d.port2 = ~{4'b0000, p2.fire_b, p2.fire_a, p1.fire_b, p1.fire_a};
				ports_d.port4 = ~{1'b0, pos.angle2[7:1]};
			end
			GAME_WACKO: begin
				orient_d      = 2'b01;
				ports_d.port1 = pos.wx;
				ports_d.port2 = pos.wy;
				ports_d.port4 = ~{2{m.fire_c, m.fire_b, m.fire_d, m.fire_a}};
			end
			GAME_KROOZR: begin
				orient_d      = 2'b01;
				ports_d.port1 = ~{m.fire_b, pos.shared[7], 3'b000, pos.shared[6:4]};
				// Digital stick mapped onto the analog pot reading
				if (m.left) begin
					ports_d.port2 = ANALOG_CENTER - ANALOG_SWING;
				end else if (m.right) begin
					ports_d.port2 = ANALOG_CENTER + ANALOG_SWING;
				end else begin
					ports_d.port2 = ANALOG_CENTER;
				end
				if (m.up) begin
					ports_d.port4 = ANALOG_CENTER - ANALOG_SWING;
				end else if (m.down) begin
					ports_d.port4 = ANALOG_CENTER + ANALOG_SWING;
				end else begin
					ports_d.port4 = ANALOG_CENTER;
				end
			end
			GAME_DOMINO: begin
				orient_d      = 2'b01;
				ports_d.port1 = ~{4'b0000, m.down, m.up, m.right, m.left};
				ports_d.port2 = ~{3'b000, m.fire_a, m.down, m.up, m.right, m.left};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ports       <= '1;
			orientation <= 2'b00;
		end else begin
			ports       <= ports_d;
			orientation <= orient_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mcr_input_top.sv
/*
 * Top level of the MCR2 player input path. Connects joystick decode,
 * game configuration, spinner bank and the input port mux.
 */

`timescale 1ns/1ns
`default_nettype none

module mcr_input_top import mcr_input_pkg::*; #(
	parameter int spin_step_shared = 12,
	parameter int spin_step_angle  = 25,
	parameter int spin_step_axis   = 10
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	input  joy_word_t    joy1,
	input  joy_word_t    joy2,
	input  cfg_write_t   cfg,
	input  logic         vsync,
	output input_ports_t ports,
	output logic [1:0]   orientation
);

	player_ctrl_t p1;
	player_ctrl_t p2;
	merged_ctrl_t merged;
	game_e        game;
	logic [7:0]   dip0;
	logic         service;
	spin_pos_t    pos;

	control_merge u_control_merge (
		.joy1   (joy1),
		.joy2   (joy2),
		.p1     (p1),
		.p2     (p2),
		.merged (merged)
	);

	game_config u_game_config (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cfg     (cfg),
		.game    (game),
		.dip0    (dip0),
		.service (service)
	);

	spinner_bank #(
		.spin_step_shared (spin_step_shared),
		.spin_step_angle  (spin_step_angle),
		.spin_step_axis   (spin_step_axis)
	) u_spinner_bank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.vsync   (vsync),
		.p1      (p1),
		.p2      (p2),
		.merged  (merged),
		.pos     (pos)
	);

	input_port_mux u_input_port_mux (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.game        (game),
		.dip0        (dip0),
		.service     (service),
		.merged      (merged),
		.p1          (p1),
		.p2          (p2),
		.pos         (pos),
		.ports       (ports),
		.orientation (orientation)
	);

endmodule

`default_nettype wire

//--- testbench/tb_ref.svh
/*
 * Testbench helpers: Fibonacci LFSR step, reference model of the
 * five input ports and orientation, and the value compare task.
 */

`ifndef TB_REF_SVH
`define TB_REF_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// ==================================================
// Expected port values from game, DIP and spinner state
// ==================================================
function automatic input_ports_t ref_ports(input logic [7:0] game, input logic [7:0] dip_0,
		input logic service, input joy_word_t j1, input joy_word_t j2, input spin_pos_t sp);
	joy_word_t    m;
	logic         btn;
	input_ports_t r;
	m = j1 | j2;
	case (game)
		GAME_TRON, GAME_KROOZR, GAME_DOMINO: btn = m[4];
		GAME_TWOTIGER:                       btn = m[6];
		default:                             btn = 1'b0;
	endcase
	r.port0 = ~{service, 2'b00, btn, m[11], m[10], 1'b0, m[12]};
	r.port1 = 8'hff;
	r.port2 = 8'hff;
	r.port3 = dip_0;
	r.port4 = 8'hff;
	case (game)
		GAME_SHOLLOW: r.port1 = ~{m[4], m[5], m[0], m[1], m[4], m[5], m[0], m[1]};
		GAME_TRON: begin
			r.port1    = ~{1'b0, sp.shared[7:1]};
			r.port4    = ~{1'b0, sp.shared[7:1]};
			r.port2    = ~{m[2], m[3], m[0], m[1], m[2], m[3], m[0], m[1]};
			r.port3[7] = ~m[4];
		end
		GAME_TWOTIGER: begin
			r.port1 = ~{1'b0, sp.angle1[7:1]};
			r.port4 = ~{1'b0, sp.angle2[7:1]};
			r.port2 = ~{4'b0000, j2[5], j2[4], j1[5], j1[4]};
		end
		GAME_WACKO: begin
			r.port1 = sp.wx;
			r.port2 = sp.wy;
			r.port4 = ~{m[6], m[5], m[7], m[4], m[6], m[5], m[7], m[4]};
		end
		GAME_KROOZR: begin
			r.port1 = ~{m[5], sp.shared[7], 3'b000, sp.shared[6:4]};
			// Stick emulates a pot centered at 100 with a throw of 63
			r.port2 = m[1] ? 8'd37 : (m[0] ? 8'd163 : 8'd100);
			r.port4 = m[3] ? 8'd37 : (m[2] ? 8'd163 : 8'd100);
		end
		GAME_DOMINO: begin
			r.port1 = ~{4'b0000, m[2], m[3], m[0], m[1]};
			r.port2 = ~{3'b000, m[4], m[2], m[3], m[0], m[1]};
		end
		default: begin
		end
	endcase
	return r;
endfunction

function automatic logic [1:0] ref_orientation(input logic [7:0] game);
	return (game >= 8'd2 && game <= 8'd5) ? 2'b01 : 2'b00;
endfunction

task automatic compare_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
	if (expected !== actual) begin
		$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		stop_with_failure();
	end
endtask

`endif

//--- testbench/tb_mcr_input.sv
/*
 * Testbench for mcr_input_top: reset defaults, DIP loading, per-game
 * button mapping with random joystick words, spinners and axes.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_mcr_input import mcr_input_pkg::*;;

	localparam logic [7:0] STEP_SHARED = 8'd12;
	localparam logic [7:0] STEP_ANGLE  = 8'd25;
	localparam logic [7:0] STEP_AXIS   = 8'd10;
	localparam int         WATCHDOG    = 20000;
	localparam int         DONE_LIMIT  = 20;

	logic         clk_sys;
	logic         rst_n;
	joy_word_t    joy1;
	joy_word_t    joy2;
	cfg_write_t   cfg;
	logic         vsync;
	input_ports_t ports;
	logic [1:0]   orientation;

	// Testbench copy of the design state
	logic [7:0]   model_game;
	logic [7:0]   model_dip [8];
	spin_pos_t    model_pos;

	logic [31:0]  lfsr_state = 32'h1c4e_20d5;
	int           check_req = 0;
	int           check_done = 0;
	string        check_name = "";

	joy_word_t kroozr_dirs [9] = '{32'h0, 32'h2, 32'h1, 32'h3, 32'h8,
		32'h4, 32'hc, 32'h100, 32'h200};

	task automatic stop_with_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	`include "tb_ref.svh"

	mcr_input_top uut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.joy1        (joy1),
		.joy2        (joy2),
		.cfg         (cfg),
		.vsync       (vsync),
		.ports       (ports),
		.orientation (orientation)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ==================================================
	// Stimulus helpers, all end 2 ns after a rising edge
	// ==================================================
	task automatic step_clocks(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
		#2;
	endtask

	task automatic rand_word(output joy_word_t w);
		for (int i = 0; i < 32; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w[i] = lfsr_state[0];
		end
	endtask

	task automatic cfg_write(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		cfg.wr    = 1'b1;
		cfg.index = index;
		cfg.addr  = addr;
		cfg.data  = data;
		if (index == 8'd1) begin
			model_game = data;
		end else if (index == 8'd254 && addr < 25'd8) begin
			model_dip[addr[2:0]] = data;
		end
		step_clocks(1);
		cfg.wr = 1'b0;
	endtask

	function automatic logic [7:0] step8(input logic [7:0] p, input logic plus,
			input logic minus, input logic [7:0] step);
		if (plus) begin
			return p + step;
		end else if (minus) begin
			return p - step;
		end
		return p;
	endfunction

	// Spinner model, one step per vsync rising edge
	task automatic model_spin_step();
		joy_word_t m;
		m = joy1 | joy2;
		model_pos.shared = step8(model_pos.shared, m[8] | m[31], m[9] | m[30], STEP_SHARED);
		model_pos.angle1 = step8(model_pos.angle1, joy1[8] | joy1[0] | joy1[31],
			joy1[9] | joy1[1] | joy1[30], STEP_ANGLE);
		model_pos.angle2 = step8(model_pos.angle2, joy2[8] | joy2[0] | joy2[31],
			joy2[9] | joy2[1] | joy2[30], STEP_ANGLE);
		model_pos.wx = step8(model_pos.wx, m[0], m[1], STEP_AXIS);
		model_pos.wy = step8(model_pos.wy, m[3], m[2], STEP_AXIS);
	endtask

	task automatic vsync_pulse();
		vsync = 1'b1;
		model_spin_step();
		step_clocks(2);
		vsync = 1'b0;
		step_clocks(4);
	endtask

	// Hands a check to the compare process and waits for it to finish
	task automatic request_check(input string name);
		int waited;
		waited = 0;
		check_name = name;
		check_req = check_req + 1;
		while (check_done != check_req && waited < DONE_LIMIT) begin
			@(posedge clk_sys);
			waited++;
		end
		if (check_done != check_req) begin
			$display("Timeout: compare for %s did not finish", name);
			stop_with_failure();
		end
		#2;
	endtask

	task automatic run_pulses(input string name, input int n);
		for (int i = 0; i < n; i++) begin
			vsync_pulse();
			request_check($sformatf("%s pulse %0d", name, i));
		end
	endtask

	// ==================================================
	// Compare process
	// ==================================================
	initial begin
		input_ports_t exp;
		forever begin
			@(posedge clk_sys);
			if (check_req != check_done) begin
				for (int i = 0; i < 3; i++) begin
					@(posedge clk_sys);
				end
				@(negedge clk_sys);
				exp = ref_ports(model_game, model_dip[0], model_dip[1][0], joy1, joy2,
					model_pos);
				compare_value({check_name, " port0"}, exp.port0, ports.port0);
				compare_value({check_name, " port1"}, exp.port1, ports.port1);
				compare_value({check_name, " port2"}, exp.port2, ports.port2);
				compare_value({check_name, " port3"}, exp.port3, ports.port3);
				compare_value({check_name, " port4"}, exp.port4, ports.port4);
				compare_value({check_name, " orientation"}, {6'b0, ref_orientation(model_game)},
					{6'b0, orientation});
				check_done = check_req;
			end
		end
	end

	initial begin
		for (int i = 0; i < WATCHDOG; i++) begin
			@(posedge clk_sys);
		end
		$display("Timeout: simulation ran past %0d clocks", WATCHDOG);
		stop_with_failure();
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		joy_word_t a;
		joy_word_t b;
		rst_n      = 1'b0;
		joy1       = '0;
		joy2       = '0;
		cfg        = '0;
		vsync      = 1'b0;
		model_game = 8'd0;
		model_pos  = '0;
		for (int i = 0; i < 8; i++) begin
			model_dip[i] = 8'hff;
		end
		step_clocks(10);
		rst_n = 1'b1;
		request_check("reset defaults");

		// DIP bank
		cfg_write(8'd254, 25'd0, 8'h5a);
		request_check("dip0 write");
		cfg_write(8'd254, 25'd1, 8'hfe);
		request_check("dip1 service");
		cfg_write(8'd254, 25'd8, 8'h00);
		request_check("dip addr 8");
		cfg_write(8'd254, 25'h100000, 8'h00);
		request_check("dip addr high");
		cfg_write(8'd7, 25'd0, 8'h00);
		request_check("other index");

		// Random button mapping per game
		for (int g = 0; g < 6; g++) begin
			cfg_write(8'd1, 25'd0, 8'(g));
			for (int n = 0; n < 40; n++) begin
				rand_word(a);
				rand_word(b);
				joy1 = a;
				joy2 = b;
				request_check($sformatf("game %0d word %0d", g, n));
			end
		end

		// Tron shared spinner, wraps after 22 steps
		joy1 = '0;
		joy2 = '0;
		cfg_write(8'd1, 25'd0, 8'd1);
		joy1 = 32'h100;
		run_pulses("tron rcw", 24);
		joy1 = '0;
		joy2 = 32'h4000_0000;
		run_pulses("tron spccw", 6);
		joy1 = 32'h100;
		joy2 = 32'h200;
		run_pulses("tron both", 3);
		joy1 = '0;
		joy2 = '0;
		run_pulses("tron idle", 3);

		// Two Tigers angles
		cfg_write(8'd1, 25'd0, 8'd2);
		joy1 = 32'h1;
		joy2 = 32'h200;
		run_pulses("twotiger turn", 12);
		joy1 = 32'h8000_0000;
		joy2 = 32'h2;
		run_pulses("twotiger spin", 4);
		joy1 = '0;
		joy2 = '0;
		run_pulses("twotiger idle", 3);

		// Wacko axes
		cfg_write(8'd1, 25'd0, 8'd3);
		joy1 = 32'h9;
		run_pulses("wacko right up", 28);
		joy1 = '0;
		joy2 = 32'h6;
		run_pulses("wacko left down", 5);
		joy1 = 32'h1;
		joy2 = 32'h2;
		run_pulses("wacko both", 2);
		joy1 = '0;
		joy2 = '0;
		run_pulses("wacko idle", 2);

		// Krooz'r stick and dial
		cfg_write(8'd1, 25'd0, 8'd4);
		for (int k = 0; k < 9; k++) begin
			joy1 = kroozr_dirs[k];
			run_pulses($sformatf("kroozr dir %0d", k), 2);
		end

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+testbench
verilog/mcr_input_pkg.sv
verilog/control_merge.sv
verilog/game_config.sv
verilog/spinner.sv
verilog/spinner_bank.sv
verilog/input_port_mux.sv
verilog/mcr_input_top.sv
testbench/tb_mcr_input.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mcr_input
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
